//--- verilog/ntt_ctrl_pkg.sv
package ntt_ctrl_pkg;

    // ------------------------------------------------------------------------
    // Memory addressing
    // ------------------------------------------------------------------------
    localparam int MEM_ADDR_WIDTH = 15;

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Round index 0..4, access index 0..64
    typedef logic [2:0] round_t;
    typedef logic [6:0] idx_t;
    typedef logic [6:0] twiddle_addr_t;

    // Forward NTT or point-wise operation
    typedef enum logic [1:0] {
        ct  = 2'd0,
        pwo = 2'd1
    } mode_t;

    // ------------------------------------------------------------------------
    // Round constants
    // ------------------------------------------------------------------------
    localparam idx_t      NUM_ACCESSES    = 7'd64;
    localparam round_t    NTT_NUM_ROUNDS  = 3'd4;
    localparam round_t    PWO_NUM_ROUNDS  = 3'd1;
    localparam mem_addr_t NTT_READ_STRIDE = 15'd16;

    // First twiddle of each forward round, entry 0 is round 0
    localparam logic [3:0][6:0] TWIDDLE_BASE = {7'd21, 7'd5, 7'd1, 7'd0};

    // ------------------------------------------------------------------------
    // Base addresses and request bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        mem_addr_t src_base;
        mem_addr_t interim_base;
        mem_addr_t dest_base;
    } ntt_mem_addr_t;

    typedef struct packed {
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } pwo_mem_addr_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_wr_req_t;

    typedef struct packed {
        logic      en;
        logic      en_c;
        mem_addr_t addr_a;
        mem_addr_t addr_b;
        mem_addr_t addr_c;
    } pwo_rd_req_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr_c;
    } pwo_wr_req_t;

    // FSM encodings
    typedef enum logic [1:0] {RD_IDLE, RD_STAGE, RD_EXEC, RD_DONE} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_STAGE, WR_MEM, WR_DONE} wr_state_t;

endpackage

//--- verilog/ntt_round_seq.sv
module ntt_round_seq (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  ntt_ctrl_pkg::mode_t  ntt_mode,
    input  logic                 ntt_enable,
    input  logic                 round_done,
    output ntt_ctrl_pkg::round_t round,
    output logic                 round_start,
    output logic                 busy,
    output logic                 done
);
    import ntt_ctrl_pkg::*;

    // Mode captured when the operation is accepted
    mode_t  mode_q;
    round_t num_rounds;
    logic   last_round;

    always_comb begin
        // Four rounds for forward NTT, a single pass for point-wise
        num_rounds = (mode_q == ct) ? NTT_NUM_ROUNDS : PWO_NUM_ROUNDS;
        last_round = (round == num_rounds - round_t'(1));
    end

    // ------------------------------------------------------------------------
    // Start, round count, finish
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q      <= ct;
            round       <= '0;
            round_start <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else if (zeroize) begin
            mode_q      <= ct;
            round       <= '0;
            round_start <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            // Both strobes are single-cycle
            round_start <= 1'b0;
            done        <= 1'b0;
            if (!busy && ntt_enable) begin
                // Enable is only looked at while idle
                mode_q      <= ntt_mode;
                round       <= '0;
                round_start <= 1'b1;
                busy        <= 1'b1;
            end else if (busy && round_done) begin
                // Round index ends at num_rounds once the op is finished
                round <= round + round_t'(1);
                if (last_round) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    round_start <= 1'b1;
                end
            end
        end
    end

    // done only ever closes an operation that was running
    a_done_after_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> $past(busy))
        else $error("done without busy in previous cycle");

    a_round_bound: assert property (@(posedge clk) disable iff (!reset_n)
        round <= num_rounds)
        else $error("round %0d beyond round count %0d", round, num_rounds);

endmodule

//--- verilog/ntt_read_side.sv
module ntt_read_side (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  ntt_ctrl_pkg::mode_t         ntt_mode,
    input  ntt_ctrl_pkg::round_t        round,
    input  logic                        round_start,
    input  logic                        sampler_valid,
    input  logic                        accumulate,
    input  ntt_ctrl_pkg::ntt_mem_addr_t ntt_base,
    input  ntt_ctrl_pkg::pwo_mem_addr_t pwo_base,
    output ntt_ctrl_pkg::mem_rd_req_t   mem_rd,
    output ntt_ctrl_pkg::pwo_rd_req_t   pwo_rd,
    output ntt_ctrl_pkg::twiddle_addr_t twiddle_addr,
    output logic                        bf_enable
);
    import ntt_ctrl_pkg::*;

    rd_state_t     rd_state;
    rd_state_t     rd_state_nxt;
    idx_t          rd_idx;
    mem_addr_t     rd_base;
    mem_addr_t     stride_offset;
    twiddle_addr_t tw_offset;
    logic          ntt_fire;
    logic          pwo_fire;
    logic          rd_fire;
    logic          last_rd;

    // ------------------------------------------------------------------------
    // Read qualifiers
    // ------------------------------------------------------------------------
    always_comb begin
        // Forward NTT reads back to back, point-wise waits on the sampler
        ntt_fire = (rd_state == RD_EXEC) && (ntt_mode == ct);
        pwo_fire = (rd_state == RD_EXEC) && (ntt_mode == pwo) && sampler_valid;
        rd_fire  = ntt_fire || pwo_fire;
        last_rd  = (rd_idx == NUM_ACCESSES - idx_t'(1));
    end

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            RD_IDLE, RD_DONE: begin
                if (round_start) begin
                    rd_state_nxt = RD_STAGE;
                end
            end
            RD_STAGE: begin
                rd_state_nxt = RD_EXEC;
            end
            RD_EXEC: begin
                // Leave after the 64th read of the round
                if (rd_fire && last_rd) begin
                    rd_state_nxt = RD_DONE;
                end
            end
            default: begin
                rd_state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state  <= RD_IDLE;
            rd_idx    <= '0;
            bf_enable <= 1'b0;
        end else if (zeroize) begin
            rd_state  <= RD_IDLE;
            rd_idx    <= '0;
            bf_enable <= 1'b0;
        end else begin
            rd_state <= rd_state_nxt;
            // Butterfly sees operands one cycle after the memory read
            bf_enable <= rd_fire;
            if (rd_state == RD_STAGE) begin
                rd_idx <= '0;
            end else if (rd_fire) begin
                rd_idx <= rd_idx + idx_t'(1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Addresses
    // ------------------------------------------------------------------------
    always_comb begin
        // Source first, then interim and dest alternate
        if (round == '0) begin
            rd_base = ntt_base.src_base;
        end else if (round[0]) begin
            rd_base = ntt_base.interim_base;
        end else begin
            rd_base = ntt_base.dest_base;
        end
        // Column walk: 0, 16, 32, 48, 1, 17 ...
        stride_offset = mem_addr_t'(rd_idx[1:0]) * NTT_READ_STRIDE
                      + mem_addr_t'(rd_idx[5:2]);
        // Twiddle index is i mod 4^r
        case (round)
            3'd1:    tw_offset = twiddle_addr_t'(rd_idx[1:0]);
            3'd2:    tw_offset = twiddle_addr_t'(rd_idx[3:0]);
            3'd3:    tw_offset = twiddle_addr_t'(rd_idx[5:0]);
            default: tw_offset = '0;
        endcase
        twiddle_addr = TWIDDLE_BASE[round[1:0]] + tw_offset;

        mem_rd.en     = ntt_fire;
        mem_rd.addr   = rd_base + stride_offset;
        // Accumulator read only when asked to accumulate
        pwo_rd.en     = pwo_fire;
        pwo_rd.en_c   = pwo_fire && accumulate;
        pwo_rd.addr_a = pwo_base.base_a + mem_addr_t'(rd_idx);
        pwo_rd.addr_b = pwo_base.base_b + mem_addr_t'(rd_idx);
        pwo_rd.addr_c = pwo_base.base_c + mem_addr_t'(rd_idx);
    end

    a_rd_mutex: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_rd.en && pwo_rd.en))
        else $error("forward and point-wise reads together");

    a_rd_idx_bound: assert property (@(posedge clk) disable iff (!reset_n)
        rd_fire |=> rd_idx <= NUM_ACCESSES)
        else $error("read index %0d past round end", rd_idx);

endmodule

//--- verilog/ntt_write_side.sv
module ntt_write_side (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  ntt_ctrl_pkg::mode_t         ntt_mode,
    input  ntt_ctrl_pkg::round_t        round,
    input  logic                        round_start,
    input  logic                        butterfly_ready,
    input  ntt_ctrl_pkg::ntt_mem_addr_t ntt_base,
    input  ntt_ctrl_pkg::pwo_mem_addr_t pwo_base,
    output ntt_ctrl_pkg::mem_wr_req_t   mem_wr,
    output ntt_ctrl_pkg::pwo_wr_req_t   pwo_wr,
    output logic                        round_done
);
    import ntt_ctrl_pkg::*;

    wr_state_t wr_state;
    wr_state_t wr_state_nxt;
    idx_t      wr_cnt;
    mem_addr_t wr_base;
    logic      wr_fire;
    logic      last_wr;

    always_comb begin
        // Even rounds land in interim, odd rounds in dest
        wr_base = round[0] ? ntt_base.dest_base : ntt_base.interim_base;
        wr_fire = (wr_state == WR_MEM) && butterfly_ready;
        last_wr = (wr_cnt == NUM_ACCESSES - idx_t'(1));
    end

    // ------------------------------------------------------------------------
    // Write FSM
    // ------------------------------------------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            WR_IDLE, WR_DONE: begin
                if (round_start) begin
                    wr_state_nxt = WR_STAGE;
                end
            end
            WR_STAGE: begin
                wr_state_nxt = WR_MEM;
            end
            WR_MEM: begin
                // Latency varies, only the write count ends the round
                if (wr_fire && last_wr) begin
                    wr_state_nxt = WR_DONE;
                end
            end
            default: begin
                wr_state_nxt = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state   <= WR_IDLE;
            wr_cnt     <= '0;
            mem_wr     <= '0;
            pwo_wr     <= '0;
            round_done <= 1'b0;
        end else if (zeroize) begin
            wr_state   <= WR_IDLE;
            wr_cnt     <= '0;
            mem_wr     <= '0;
            pwo_wr     <= '0;
            round_done <= 1'b0;
        end else begin
            wr_state <= wr_state_nxt;
            if (wr_state == WR_STAGE) begin
                wr_cnt <= '0;
            end else if (wr_fire) begin
                wr_cnt <= wr_cnt + idx_t'(1);
            end
            // Request goes out one cycle after butterfly_ready
            mem_wr.en     <= wr_fire && (ntt_mode == ct);
            mem_wr.addr   <= wr_base + mem_addr_t'(wr_cnt);
            pwo_wr.en     <= wr_fire && (ntt_mode == pwo);
            pwo_wr.addr_c <= pwo_base.base_c + mem_addr_t'(wr_cnt);
            // Lines up with the 64th write
            round_done    <= wr_fire && last_wr;
        end
    end

    // A result arriving while idle would be dropped without a write
    a_no_wr_idle: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_state == WR_IDLE) |-> !butterfly_ready)
        else $error("butterfly result while write FSM idle");

    // All 64 results already taken, butterfly must be drained
    a_no_extra_ready: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (wr_state == WR_DONE) |-> !butterfly_ready)
        else $error("butterfly_ready after 64 writes of round %0d", round);

endmodule

//--- verilog/ntt_ctrl_top.sv
module ntt_ctrl_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  ntt_ctrl_pkg::mode_t         ntt_mode,
    input  logic                        ntt_enable,
    input  logic                        sampler_valid,
    input  logic                        accumulate,
    input  logic                        butterfly_ready,
    input  ntt_ctrl_pkg::ntt_mem_addr_t ntt_base,
    input  ntt_ctrl_pkg::pwo_mem_addr_t pwo_base,
    output ntt_ctrl_pkg::mem_rd_req_t   mem_rd,
    output ntt_ctrl_pkg::mem_wr_req_t   mem_wr,
    output ntt_ctrl_pkg::pwo_rd_req_t   pwo_rd,
    output ntt_ctrl_pkg::pwo_wr_req_t   pwo_wr,
    output ntt_ctrl_pkg::twiddle_addr_t twiddle_addr,
    output logic                        bf_enable,
    output logic                        busy,
    output logic                        done
);
    import ntt_ctrl_pkg::*;

    // Round control shared by both sides
    round_t round;
    logic   round_start;
    // Write side reports the 64th write back to the sequencer
    logic   round_done;

    ntt_round_seq u_round_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .ntt_mode    (ntt_mode),
        .ntt_enable  (ntt_enable),
        .round_done  (round_done),
        .round       (round),
        .round_start (round_start),
        .busy        (busy),
        .done        (done)
    );

    ntt_read_side u_read_side (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .ntt_mode      (ntt_mode),
        .round         (round),
        .round_start   (round_start),
        .sampler_valid (sampler_valid),
        .accumulate    (accumulate),
        .ntt_base      (ntt_base),
        .pwo_base      (pwo_base),
        .mem_rd        (mem_rd),
        .pwo_rd        (pwo_rd),
        .twiddle_addr  (twiddle_addr),
        .bf_enable     (bf_enable)
    );

    ntt_write_side u_write_side (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .ntt_mode        (ntt_mode),
        .round           (round),
        .round_start     (round_start),
        .butterfly_ready (butterfly_ready),
        .ntt_base        (ntt_base),
        .pwo_base        (pwo_base),
        .mem_wr          (mem_wr),
        .pwo_wr          (pwo_wr),
        .round_done      (round_done)
    );

endmodule

//--- verification/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Reset held low for the first 3 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- verification/ntt_ctrl_tb.sv
module ntt_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ntt_ctrl_pkg::*;

    // One forward run is four rounds of about 80 cycles
    localparam int NTT_RUN_CYCLES = 4 * 80;
    localparam int PWO_RUN_CYCLES = 300;
    localparam int ABORT_CYCLES   = 120;
    // Three forward runs, one point-wise run, one aborted run and margin
    localparam int CYCLE_LIMIT = 3 * NTT_RUN_CYCLES + PWO_RUN_CYCLES + ABORT_CYCLES + 620;
    localparam logic [31:0] LFSR_SEED = 32'h5f493b69;

    logic          clk;
    logic          reset_n;
    logic          zeroize;
    mode_t         ntt_mode;
    logic          ntt_enable;
    logic          sampler_valid;
    logic          accumulate;
    logic          butterfly_ready = 1'b0;
    ntt_mem_addr_t ntt_base;
    pwo_mem_addr_t pwo_base;
    mem_rd_req_t   mem_rd;
    mem_wr_req_t   mem_wr;
    pwo_rd_req_t   pwo_rd;
    pwo_wr_req_t   pwo_wr;
    twiddle_addr_t twiddle_addr;
    logic          bf_enable;
    logic          busy;
    logic          done;

    // Reference state
    mode_t         op_mode;
    string         test_name;
    logic [31:0]   lfsr;
    logic [9:0]    bf_pipe = '0;
    idx_t          rd_idx_ref;
    idx_t          wr_idx_ref;
    round_t        rd_round;
    round_t        wr_round;
    round_t        exp_rounds;
    logic          was_cleared;
    logic          done_q;
    logic          rd_q;
    mem_addr_t     rd_base_ref;
    mem_addr_t     wr_base_ref;
    mem_addr_t     exp_rd_addr;
    mem_addr_t     exp_wr_addr;
    mem_addr_t     exp_addr_a;
    mem_addr_t     exp_addr_b;
    mem_addr_t     exp_addr_c;
    mem_addr_t     exp_wr_c;
    twiddle_addr_t exp_twiddle;
    int            cycle_count;
    int            value_errors = 0;
    int            check_errors = 0;

    tb_clock u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ntt_ctrl_top DUT (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .ntt_mode        (ntt_mode),
        .ntt_enable      (ntt_enable),
        .sampler_valid   (sampler_valid),
        .accumulate      (accumulate),
        .butterfly_ready (butterfly_ready),
        .ntt_base        (ntt_base),
        .pwo_base        (pwo_base),
        .mem_rd          (mem_rd),
        .mem_wr          (mem_wr),
        .pwo_rd          (pwo_rd),
        .pwo_wr          (pwo_wr),
        .twiddle_addr    (twiddle_addr),
        .bf_enable       (bf_enable),
        .busy            (busy),
        .done            (done)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        // Galois form, taps of x^32 + x^22 + x^2 + x + 1
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // Column walk with stride 16 over a 64-word buffer
    function automatic mem_addr_t strided_addr(input mem_addr_t base, input idx_t i);
        return base + mem_addr_t'(16 * (int'(i) % 4) + int'(i) / 4);
    endfunction

    // Round r twiddles start after 1 + 4 + ... + 4^(r-1) entries
    function automatic twiddle_addr_t twiddle_ref(input round_t r, input idx_t i);
        int first;
        int span;
        first = 0;
        span = 1;
        for (int k = 0; k < int'(r); k++) begin
            first = first + span;
            span = span * 4;
        end
        return twiddle_addr_t'(first + int'(i) % span);
    endfunction

    task automatic note_mismatch(input string what, input int expected, input int actual);
        value_errors++;
        $display("error %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
    endtask

    task automatic flag_failure(input string what);
        check_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic start_op(input mode_t mode, input string name);
        @(posedge clk);
        test_name = name;
        ntt_mode   <= mode;
        op_mode    <= mode;
        ntt_enable <= 1'b1;
    endtask

    // Random sampler and accumulate each cycle, optional enable burst while busy
    task automatic wait_for_done(input int poke_at);
        int   waited;
        logic bit_v;
        logic bit_a;
        waited = 0;
        while (!done) begin
            @(posedge clk);
            random_bit(bit_v);
            random_bit(bit_a);
            sampler_valid <= bit_v;
            accumulate    <= bit_a;
            ntt_enable    <= (poke_at > 0) && (waited >= poke_at) && (waited < poke_at + 3);
            waited++;
        end
    endtask

    task automatic abort_op(input int cycles);
        start_op(ct, "ntt_zeroize");
        repeat (cycles) begin
            @(posedge clk);
            ntt_enable <= 1'b0;
        end
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Butterfly model and reference counters
    // ------------------------------------------------------------------------
    // 10 pipe stages plus the output register give 11 cycles
    always @(posedge clk) begin
        if (!reset_n || zeroize) begin
            bf_pipe         <= '0;
            butterfly_ready <= 1'b0;
        end else begin
            bf_pipe         <= {bf_pipe[8:0], bf_enable};
            butterfly_ready <= bf_pipe[9];
        end
    end

    always @(posedge clk) begin
        was_cleared <= !reset_n || zeroize;
        done_q      <= done;
        rd_q        <= mem_rd.en || pwo_rd.en;
        if (!reset_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
        // Counters restart whenever the block is idle
        if (!reset_n || zeroize || !busy) begin
            rd_idx_ref <= '0;
            wr_idx_ref <= '0;
            rd_round   <= '0;
            wr_round   <= '0;
        end else begin
            if (mem_rd.en || pwo_rd.en) begin
                rd_idx_ref <= (rd_idx_ref == 7'd63) ? 7'd0 : rd_idx_ref + 7'd1;
                if (rd_idx_ref == 7'd63) begin
                    rd_round <= rd_round + 3'd1;
                end
            end
            if (mem_wr.en || pwo_wr.en) begin
                wr_idx_ref <= (wr_idx_ref == 7'd63) ? 7'd0 : wr_idx_ref + 7'd1;
                if (wr_idx_ref == 7'd63) begin
                    wr_round <= wr_round + 3'd1;
                end
            end
        end
    end

    always_comb begin
        // Source, then interim on odd rounds and dest on round 2
        if (rd_round == 3'd0) begin
            rd_base_ref = ntt_base.src_base;
        end else if (rd_round[0]) begin
            rd_base_ref = ntt_base.interim_base;
        end else begin
            rd_base_ref = ntt_base.dest_base;
        end
        wr_base_ref = wr_round[0] ? ntt_base.dest_base : ntt_base.interim_base;
        exp_rd_addr = strided_addr(rd_base_ref, rd_idx_ref);
        exp_twiddle = twiddle_ref(rd_round, rd_idx_ref);
        exp_wr_addr = wr_base_ref + mem_addr_t'(wr_idx_ref);
        exp_addr_a  = pwo_base.base_a + mem_addr_t'(rd_idx_ref);
        exp_addr_b  = pwo_base.base_b + mem_addr_t'(rd_idx_ref);
        exp_addr_c  = pwo_base.base_c + mem_addr_t'(rd_idx_ref);
        exp_wr_c    = pwo_base.base_c + mem_addr_t'(wr_idx_ref);
        exp_rounds  = (op_mode == ct) ? 3'd4 : 3'd1;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_idle_after_clear: assert property (@(posedge clk) disable iff (!reset_n)
        was_cleared |-> !(busy || done || bf_enable || mem_rd.en || mem_wr.en
                          || pwo_rd.en || pwo_rd.en_c || pwo_wr.en))
        else flag_failure("block not idle after reset or zeroize");

    a_rd_addr: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd.en |-> mem_rd.addr == exp_rd_addr)
        else note_mismatch("read address", int'($sampled(exp_rd_addr)),
                           int'($sampled(mem_rd.addr)));

    a_twiddle: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd.en |-> twiddle_addr == exp_twiddle)
        else note_mismatch("twiddle address", int'($sampled(exp_twiddle)),
                           int'($sampled(twiddle_addr)));

    // A read of the next round shows up as a read round ahead of the write round
    a_rd_order: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_rd.en || pwo_rd.en) |-> rd_round == wr_round)
        else flag_failure("read issued before the writes of the previous round ended");

    a_wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        mem_wr.en |-> mem_wr.addr == exp_wr_addr)
        else note_mismatch("write address", int'($sampled(exp_wr_addr)),
                           int'($sampled(mem_wr.addr)));

    a_bf_follows_rd: assert property (@(posedge clk) disable iff (!reset_n)
        !was_cleared |-> bf_enable == rd_q)
        else note_mismatch("bf_enable", int'($sampled(rd_q)), int'($sampled(bf_enable)));

    a_pwo_sampler: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_rd.en |-> sampler_valid)
        else flag_failure("point-wise read without sampler data");

    a_pwo_addr_a: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_rd.en |-> pwo_rd.addr_a == exp_addr_a)
        else note_mismatch("operand A address", int'($sampled(exp_addr_a)),
                           int'($sampled(pwo_rd.addr_a)));

    a_pwo_addr_b: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_rd.en |-> pwo_rd.addr_b == exp_addr_b)
        else note_mismatch("operand B address", int'($sampled(exp_addr_b)),
                           int'($sampled(pwo_rd.addr_b)));

    // Accumulator read exactly when reading and accumulating
    a_pwo_en_c: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_rd.en_c == (pwo_rd.en && accumulate))
        else note_mismatch("en_c", int'($sampled(pwo_rd.en && accumulate)),
                           int'($sampled(pwo_rd.en_c)));

    a_pwo_addr_c: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_rd.en_c |-> pwo_rd.addr_c == exp_addr_c)
        else note_mismatch("accumulator read address", int'($sampled(exp_addr_c)),
                           int'($sampled(pwo_rd.addr_c)));

    a_pwo_wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        pwo_wr.en |-> pwo_wr.addr_c == exp_wr_c)
        else note_mismatch("result write address", int'($sampled(exp_wr_c)),
                           int'($sampled(pwo_wr.addr_c)));

    a_mode_ports: assert property (@(posedge clk) disable iff (!reset_n)
        (op_mode == ct) ? !(pwo_rd.en || pwo_wr.en) : !(mem_rd.en || mem_wr.en))
        else flag_failure("request issued on the port of the other mode");

    // done closes the operation after all writes of all rounds
    a_done_writes: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> (wr_round == exp_rounds) && (wr_idx_ref == 7'd0))
        else note_mismatch("write count at done", 64 * int'($sampled(exp_rounds)),
                           64 * int'($sampled(wr_round)) + int'($sampled(wr_idx_ref)));

    a_done_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !busy)
        else flag_failure("busy still high in the done cycle");

    a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
        !(done && done_q))
        else flag_failure("done held for more than one cycle");

    // ------------------------------------------------------------------------
    // Watchdog and stimulus
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset_n && cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        lfsr = LFSR_SEED;
        test_name = "reset";
        zeroize       <= 1'b0;
        ntt_mode      <= ct;
        op_mode       <= ct;
        ntt_enable    <= 1'b0;
        sampler_valid <= 1'b0;
        accumulate    <= 1'b0;
        ntt_base      <= '{src_base: 15'h0100, interim_base: 15'h0400, dest_base: 15'h0800};
        pwo_base      <= '{base_a: 15'h1000, base_b: 15'h2000, base_c: 15'h3000};
        @(posedge clk);
        while (!reset_n) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        start_op(ct, "ntt_basic");
        wait_for_done(0);
        abort_op(ABORT_CYCLES);
        // New buffers for the restart
        ntt_base <= '{src_base: 15'h0a00, interim_base: 15'h0300, dest_base: 15'h7f00};
        start_op(ct, "ntt_restart");
        wait_for_done(0);
        start_op(pwo, "pwo_random");
        wait_for_done(0);
        // Enable burst in the middle of round 1
        start_op(ct, "ntt_enable_busy");
        wait_for_done(150);
        repeat (4) @(posedge clk);

        $display("closing: %0d value errors, %0d check errors", value_errors, check_errors);
        if (value_errors == 0 && check_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/ntt_ctrl_pkg.sv
verilog/ntt_round_seq.sv
verilog/ntt_read_side.sv
verilog/ntt_write_side.sv
verilog/ntt_ctrl_top.sv
verification/tb_clock.sv
verification/ntt_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module ntt_ctrl_tb -Mdir obj_dir

output=$(./obj_dir/Vntt_ctrl_tb)
echo "$output"

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
